// File: project.f
rtl/uart_pkg.sv
rtl/baud_timer.sv
rtl/bit_shifter.sv
rtl/uart_rx_ctrl.sv
rtl/uart_tx_ctrl.sv
rtl/uart_top.sv
test/uart_checker.sv
test/uart_tb.sv

// File: rtl/baud_timer.sv
`timescale 1ns/100ps
`default_nettype none

// bit timing from the system clock
// mid_o marks the sampling point, end_o the bit boundary
module baud_timer #(
  parameter int clks_per_bit = 8
) (
  input  wire  clk,
  input  wire  reset,
  input  logic restart_i,
  output logic mid_o,
  output logic end_o
);

  // counter wide enough for clks_per_bit - 1
  localparam int cnt_w = $clog2(clks_per_bit);
  // count value at which the half point is reached
  // strobe lands clks_per_bit/2 clocks after a restart
  localparam int mid_val = clks_per_bit - clks_per_bit / 2;

  logic [cnt_w-1:0] cnt;

  // end of bit when the down counter runs out
  assign end_o = (cnt == '0);
  // half point of the current bit
  assign mid_o = (cnt == cnt_w'(mid_val));

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      cnt <= cnt_w'(clks_per_bit - 1);
    end else if (restart_i || end_o) begin
      // restart realigns the bit grid to the current edge
      cnt <= cnt_w'(clks_per_bit - 1);
    end else begin
      cnt <= cnt - 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: rtl/bit_shifter.sv
`timescale 1ns/100ps
`default_nettype none

// lsb first byte shift register
// used as deserializer on rx and serializer on tx
module bit_shifter (
  input  wire             clk,
  input  wire             reset,
  input  logic            load_i,
  input  uart_pkg::byte_t load_data_i,
  input  logic            shift_i,
  input  logic            ser_i,
  output logic            ser_o,
  output uart_pkg::byte_t par_o
);

  uart_pkg::byte_t sreg;

  // serial out is the bit that goes on the line next
  assign ser_o = sreg[0];
  assign par_o = sreg;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      sreg <= '0;
    end else if (load_i) begin
      // parallel load has priority over shift
      sreg <= load_data_i;
    end else if (shift_i) begin
      // new bit enters at the msb
      // after eight shifts the first bit sits in bit 0
      sreg <= {ser_i, sreg[7:1]};
    end
  end

endmodule

`default_nettype wire

// File: rtl/uart_pkg.sv
`default_nettype none

// shared types and frame constants for the byte uart
package uart_pkg;

  // one data byte as the only payload width in the design
  typedef logic [7:0] byte_t;

  // word handed to the user on the receive handshake
  // data in the upper byte and flags in the two low bits
  typedef struct packed {
    byte_t data;
    // stop bit was sampled low
    logic  frame_err;
    // one or more frames dropped since the previous word
    logic  overrun;
  } rx_word_t;

  // data bits per frame, sent lsb first
  localparam int DATA_BITS = 8;

  // line level of the start bit
  localparam logic start_bit = 1'b0;

  // line level of the stop bit
  localparam logic stop_bit = 1'b1;

  // level of an idle line and reset value of line flops
  localparam logic line_idle = 1'b1;

endpackage

`default_nettype wire

// File: rtl/uart_rx_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

// receive side fsm and the output handshake
module uart_rx_ctrl (
  input  wire                clk,
  input  wire                reset,
  input  logic               rx_i,
  input  logic               mid_i,
  output logic               restart_o,
  output logic               shift_o,
  output logic               bit_o,
  input  uart_pkg::byte_t    par_i,
  output logic               req_o,
  output uart_pkg::rx_word_t word_o,
  input  logic               ack_i
);

  localparam int cnt_w = $clog2(uart_pkg::DATA_BITS);

  typedef enum logic [1:0] {st_idle, st_start, st_data, st_stop} state_t;

  state_t           state;
  logic [cnt_w-1:0] bit_cnt;
  // two flop synchronizer plus one more for edge detect
  logic             rx_meta;
  logic             rx_sync;
  logic             rx_prev;
  // frames lost while the handshake was busy
  logic             overrun_pend;
  logic             start_edge;
  logic             frame_done;
  logic             hs_free;

  // falling edge on an idle line starts a frame
  assign start_edge = (state == st_idle) && (rx_prev == uart_pkg::stop_bit) &&
                      (rx_sync == uart_pkg::start_bit);
  assign restart_o  = start_edge;
  // one shift per data bit, at its middle
  assign shift_o    = (state == st_data) && mid_i;
  assign bit_o      = rx_sync;
  // stop bit middle ends the frame
  assign frame_done = (state == st_stop) && mid_i;
  // previous transfer fully closed
  assign hs_free    = !req_o && !ack_i;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rx_meta <= uart_pkg::line_idle;
      rx_sync <= uart_pkg::line_idle;
      rx_prev <= uart_pkg::line_idle;
    end else begin
      rx_meta <= rx_i;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state   <= st_idle;
      bit_cnt <= '0;
    end else begin
      case (state)
        st_idle: if (start_edge) state <= st_start;
        // line back high at mid start bit means a glitch
        st_start: if (mid_i) begin
          bit_cnt <= '0;
          state   <= (rx_sync == uart_pkg::start_bit) ? st_data : st_idle;
        end
        st_data: if (mid_i) begin
          if (bit_cnt == cnt_w'(uart_pkg::DATA_BITS - 1)) state <= st_stop;
          bit_cnt <= bit_cnt + 1'b1;
        end
        st_stop: if (mid_i) state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

  // handshake register pair runs apart from the fsm
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      req_o        <= 1'b0;
      word_o       <= '0;
      overrun_pend <= 1'b0;
    end else if (frame_done && hs_free) begin
      word_o.data      <= par_i;
      word_o.frame_err <= (rx_sync != uart_pkg::stop_bit);
      word_o.overrun   <= overrun_pend;
      req_o            <= 1'b1;
      overrun_pend     <= 1'b0;
    end else begin
      // frame dropped while the sink is still busy
      if (frame_done) overrun_pend <= 1'b1;
      if (ack_i) req_o <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: rtl/uart_top.sv
`timescale 1ns/100ps
`default_nettype none

// 8n1 byte uart with req/ack user side in both directions
module uart_top #(
  parameter int clks_per_bit = 8
) (
  input  wire                clk,
  input  wire                reset,
  input  logic               rx_i,
  output logic               tx_o,
  output logic               rx_req_o,
  output uart_pkg::rx_word_t rx_word_o,
  input  logic               rx_ack_i,
  input  logic               tx_req_i,
  input  uart_pkg::byte_t    tx_data_i,
  output logic               tx_ack_o
);

  // receive path
  logic            rx_restart;
  logic            rx_mid;
  logic            rx_shift;
  logic            rx_bit;
  uart_pkg::byte_t rx_par;
  // transmit path
  logic            tx_restart;
  logic            tx_end;
  logic            tx_load;
  uart_pkg::byte_t tx_load_data;
  logic            tx_shift;
  logic            tx_ser;

  // rx samples on mid strobes only
  baud_timer #(.clks_per_bit(clks_per_bit)) rx_timer (
    .clk, .reset, .restart_i(rx_restart), .mid_o(rx_mid), .end_o()
  );

  // rx shifter never loads and only collects bits
  bit_shifter rx_shifter (
    .clk, .reset, .load_i(1'b0), .load_data_i('0), .shift_i(rx_shift),
    .ser_i(rx_bit), .ser_o(), .par_o(rx_par)
  );

  uart_rx_ctrl rx_ctrl (
    .clk, .reset, .rx_i, .mid_i(rx_mid), .restart_o(rx_restart),
    .shift_o(rx_shift), .bit_o(rx_bit), .par_i(rx_par),
    .req_o(rx_req_o), .word_o(rx_word_o), .ack_i(rx_ack_i)
  );

  // tx steps on end-of-bit strobes only
  baud_timer #(.clks_per_bit(clks_per_bit)) tx_timer (
    .clk, .reset, .restart_i(tx_restart), .mid_o(), .end_o(tx_end)
  );

  // tx shifter fills with idle level behind the data
  bit_shifter tx_shifter (
    .clk, .reset, .load_i(tx_load), .load_data_i(tx_load_data), .shift_i(tx_shift),
    .ser_i(uart_pkg::line_idle), .ser_o(tx_ser), .par_o()
  );

  uart_tx_ctrl tx_ctrl (
    .clk, .reset, .req_i(tx_req_i), .data_i(tx_data_i), .ack_o(tx_ack_o),
    .end_i(tx_end), .restart_o(tx_restart), .load_o(tx_load),
    .load_data_o(tx_load_data), .shift_o(tx_shift), .ser_i(tx_ser), .tx_o
  );

endmodule

`default_nettype wire

// File: rtl/uart_tx_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

// transmit side fsm with input handshake and registered line driver
module uart_tx_ctrl (
  input  wire             clk,
  input  wire             reset,
  input  logic            req_i,
  input  uart_pkg::byte_t data_i,
  output logic            ack_o,
  input  logic            end_i,
  output logic            restart_o,
  output logic            load_o,
  output uart_pkg::byte_t load_data_o,
  output logic            shift_o,
  input  logic            ser_i,
  output logic            tx_o
);

  localparam int cnt_w = $clog2(uart_pkg::DATA_BITS);

  typedef enum logic [1:0] {st_idle, st_start, st_data, st_stop} state_t;

  state_t           state;
  logic [cnt_w-1:0] bit_cnt;
  logic             accept;
  logic             last_bit;

  // only when idle and the previous ack has dropped
  assign accept      = (state == st_idle) && req_i && !ack_o;
  assign last_bit    = (bit_cnt == cnt_w'(uart_pkg::DATA_BITS - 1));
  // start of frame realigns the timer and loads the byte
  assign restart_o   = accept;
  assign load_o      = accept;
  assign load_data_o = data_i;
  // advance the shifter once each bit is on the line
  assign shift_o     = end_i && ((state == st_start) || ((state == st_data) && !last_bit));

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state   <= st_idle;
      bit_cnt <= '0;
      ack_o   <= 1'b0;
      tx_o    <= uart_pkg::line_idle;
    end else begin
      // ack held until the source drops req
      if (accept) ack_o <= 1'b1;
      else if (!req_i) ack_o <= 1'b0;
      case (state)
        // start bit goes out on the accepting edge
        st_idle: if (accept) begin
          state <= st_start;
          tx_o  <= uart_pkg::start_bit;
        end
        st_start: if (end_i) begin
          state   <= st_data;
          bit_cnt <= '0;
          tx_o    <= ser_i;
        end
        st_data: if (end_i) begin
          if (last_bit) begin
            state <= st_stop;
            tx_o  <= uart_pkg::stop_bit;
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
            tx_o    <= ser_i;
          end
        end
        // line stays high through the stop bit into idle
        st_stop: if (end_i) state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: test/uart_cases.txt
# op byte stop frame_err overrun delay, byte in hex, the rest in decimal
# delay is the ack delay for R and idle cycles before req for T, -1 random, -2 frame lost
R 55 1 0 0 0
R a3 1 0 0 3
R 00 1 0 0 -1
R ff 1 0 0 -1
R 81 1 0 0 -1
R 7e 1 0 0 12
R 3c 0 1 0 -1
R c3 1 0 0 -1
R 00 0 1 0 4
R 5a 1 0 0 -1
R 96 1 0 0 300
R e1 1 0 0 -2
R 69 1 0 1 -1
R 0f 1 0 0 -1
R f0 1 0 0 -1
T 55 1 0 0 5
T a5 1 0 0 -1
T 00 1 0 0 -1
T ff 1 0 0 -1
T 01 1 0 0 0
T 80 1 0 0 0
T 3c 1 0 0 0
T d2 1 0 0 -1
R 24 1 0 0 -1
T 4b 1 0 0 2
R b7 1 0 0 -1

// File: test/uart_checker.sv
`timescale 1ns/100ps
`default_nettype none

// watches the uart pins and compares with queued expectations
module uart_checker (
  input wire                clk,
  input wire                reset,
  input logic               tx_i,
  input logic               rx_req_i,
  input uart_pkg::rx_word_t rx_word_i,
  input logic               rx_ack_i,
  input logic               tx_ack_i
);

  uart_pkg::rx_word_t rx_q[$];
  uart_pkg::byte_t    tx_q[$];
  uart_pkg::rx_word_t exp_w;
  uart_pkg::rx_word_t held_w;
  uart_pkg::byte_t    tx_cur;
  logic               tx_exp;
  logic               req_q;
  logic               ack_q;
  logic               tx_ack_q;
  // frame on tx_o with cycles counted from its start
  logic               tx_active = 1'b0;
  int                 tx_cnt = 0;
  int                 settle = 0;
  int                 value_errs = 0;
  int                 proto_errs = 0;

  task automatic expect_word(input uart_pkg::rx_word_t w);
    rx_q.push_back(w);
  endtask

  task automatic queue_tx_byte(input uart_pkg::byte_t b);
    tx_q.push_back(b);
  endtask

  function automatic logic drained();
    return rx_q.size() == 0 && tx_q.size() == 0 && !tx_active;
  endfunction

  task automatic compare(input string name, input logic [15:0] got, input logic [15:0] exp);
    if (got !== exp) begin
      $display("ERROR %s got %h expected %h", name, got, exp);
      value_errs++;
    end
  endtask

  task automatic complain(input string what);
    $display("%s", what);
    proto_errs++;
  endtask

  // idle levels in reset and the first cycles after it
  always @(negedge clk) begin
    if (reset || settle < 4) begin
      compare("tx_o", tx_i, 16'h1);
      compare("rx_req_o", rx_req_i, 16'h0);
      compare("tx_ack_o", tx_ack_i, 16'h0);
      compare("rx_word_o", rx_word_i, 16'h0);
    end
    settle = reset ? 0 : settle + 1;
  end

  always @(posedge clk) begin
    if (reset) begin
      tx_active = 1'b0;
      req_q     = 1'b0;
      ack_q     = 1'b0;
      tx_ack_q  = 1'b0;
    end else begin
      // tx ack only starts a frame on a free line
      if (tx_ack_i && !tx_ack_q) begin
        if (tx_active) complain("tx_ack_o rose while a frame was still on tx_o");
        compare("tx_o at tx_ack_o rise", tx_i, 16'h0);
      end
      if (!tx_active && tx_i === 1'b0) begin
        tx_active = 1'b1;
        tx_cnt    = 0;
        if (tx_q.size() == 0) complain("frame on tx_o with no byte requested");
        else tx_cur = tx_q.pop_front();
      end else if (tx_active) begin
        tx_cnt++;
        // mid bit samples of start then data lsb first then stop
        if (tx_cnt % 8 == 4) begin
          if (tx_cnt / 8 == 0) tx_exp = 1'b0;
          else if (tx_cnt / 8 == 9) tx_exp = 1'b1;
          else tx_exp = tx_cur[tx_cnt / 8 - 1];
          compare($sformatf("tx_o bit %0d", tx_cnt / 8), tx_i, tx_exp);
        end
        if (tx_cnt == 79) tx_active = 1'b0;
      end
      // rx word checked once at req rise
      if (rx_req_i && !req_q) begin
        if (rx_ack_i) complain("rx_req_o rose while rx_ack_i was still high");
        if (rx_q.size() == 0) complain("word on rx_word_o with none expected");
        else begin
          exp_w = rx_q.pop_front();
          compare("rx_word_o.data", rx_word_i.data, exp_w.data);
          compare("rx_word_o.frame_err", rx_word_i.frame_err, exp_w.frame_err);
          compare("rx_word_o.overrun", rx_word_i.overrun, exp_w.overrun);
        end
        held_w = rx_word_i;
      end else if (rx_req_i && rx_word_i !== held_w) begin
        compare("rx_word_o under rx_req_o", rx_word_i, held_w);
        held_w = rx_word_i;
      end
      if (!rx_req_i && req_q && !ack_q) complain("rx_req_o dropped before rx_ack_i");
      req_q    = rx_req_i;
      ack_q    = rx_ack_i;
      tx_ack_q = tx_ack_i;
    end
  end

endmodule

`default_nettype wire

// File: test/uart_tb.sv
`timescale 1ns/100ps
`default_nettype none

// uart testbench driven by test/uart_cases.txt
module uart_tb;

  logic               clk;
  logic               reset;
  logic               rx_i;
  logic               rx_ack_i;
  logic               tx_req_i;
  logic               tx_o;
  logic               rx_req_o;
  logic               tx_ack_o;
  uart_pkg::byte_t    tx_data_i;
  uart_pkg::rx_word_t rx_word_o;
  logic [31:0]        lfsr = 32'h4ee5ea57;
  // ack delay per expected rx word, in send order
  int                 ack_delays[$];
  int                 acks_sent = 0;
  int                 acks_done = 0;
  int                 timeouts = 0;
  int                 bad_cases = 0;

  uart_top #(.clks_per_bit(8)) UUT (
    .clk, .reset, .rx_i, .tx_o, .rx_req_o, .rx_word_o, .rx_ack_i,
    .tx_req_i, .tx_data_i, .tx_ack_o
  );

  uart_checker chk (
    .clk, .reset, .tx_i(tx_o), .rx_req_i(rx_req_o), .rx_word_i(rx_word_o),
    .rx_ack_i, .tx_ack_i(tx_ack_o)
  );

  always #2 clk = ~clk;

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // five random bits with one lfsr step per bit
  task automatic draw_delay(output int d);
    d = 0;
    repeat (5) begin
      lfsr = lfsr_next(lfsr);
      d    = (d << 1) | lfsr[0];
    end
  endtask

  task automatic finish_run();
    $display("errors: value %0d, protocol %0d, timeout %0d, case file %0d",
             chk.value_errs, chk.proto_errs, timeouts, bad_cases);
    if (chk.value_errs + chk.proto_errs + timeouts + bad_cases == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  endtask

  // one clock of a bounded wait
  task automatic tick_or_quit(inout int n, input string what);
    @(posedge clk);
    n++;
    if (n > 2000) begin
      $display("timeout while waiting for %s", what);
      timeouts++;
      finish_run();
    end
  endtask

  // one 8 clock serial bit on rx_i
  task automatic drive_bit(input logic v);
    @(posedge clk);
    rx_i <= v;
    repeat (7) @(posedge clk);
  endtask

  task automatic send_frame(input uart_pkg::byte_t b, input logic stop);
    drive_bit(1'b0);
    for (int i = 0; i < 8; i++) drive_bit(b[i]);
    drive_bit(stop);
    // idle gap so a low stop bit still gives a clean start edge
    drive_bit(1'b1);
    drive_bit(1'b1);
  endtask

  // rx sink acks each word after its own delay
  initial begin : rx_sink
    int n;
    int d;
    forever begin
      @(posedge clk);
      if (ack_delays.size() > 0) begin
        d = ack_delays.pop_front();
        n = 0;
        while (rx_req_o !== 1'b1) tick_or_quit(n, "rx_req_o to rise");
        repeat (d) @(posedge clk);
        rx_ack_i <= 1'b1;
        n = 0;
        while (rx_req_o !== 1'b0) tick_or_quit(n, "rx_req_o to drop");
        rx_ack_i <= 1'b0;
        acks_done++;
      end
    end
  end

  task automatic run_case(input logic [63:0] op, input uart_pkg::byte_t b, input int stop,
                          input int fe, input int ov, input int delay);
    int                 d;
    int                 n;
    uart_pkg::rx_word_t w;
    d = delay;
    if (delay == -1) draw_delay(d);
    if (op == "R") begin
      // a lost frame goes out while the previous word is still held
      if (delay != -2) begin
        n = 0;
        while (acks_done != acks_sent) tick_or_quit(n, "rx handshake to close");
        w.data      = b;
        w.frame_err = fe[0];
        w.overrun   = ov[0];
        chk.expect_word(w);
        ack_delays.push_back(d);
        acks_sent++;
      end
      send_frame(b, stop[0]);
    end else if (op == "T") begin
      repeat (d) @(posedge clk);
      @(posedge clk);
      tx_req_i  <= 1'b1;
      tx_data_i <= b;
      chk.queue_tx_byte(b);
      n = 0;
      while (tx_ack_o !== 1'b1) tick_or_quit(n, "tx_ack_o to rise");
      tx_req_i <= 1'b0;
      n = 0;
      while (tx_ack_o !== 1'b0) tick_or_quit(n, "tx_ack_o to drop");
    end else begin
      $display("case file holds an unknown operation");
      bad_cases++;
    end
  endtask

  initial begin : main
    int              fd;
    int              n;
    int              b;
    int              stop;
    int              fe;
    int              ov;
    int              delay;
    logic [63:0]     tok;
    logic [8*96-1:0] rest;
    clk       = 1'b0;
    reset     = 1'b1;
    rx_i      = 1'b1;
    rx_ack_i  = 1'b0;
    tx_req_i  = 1'b0;
    tx_data_i = '0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    fd = $fopen("test/uart_cases.txt", "r");
    if (fd == 0) begin
      $display("cannot open the case file test/uart_cases.txt");
      bad_cases++;
    end else begin
      while ($fscanf(fd, "%s", tok) == 1) begin
        // comment lines open with a lone hash
        if (tok == "#") n = $fgets(rest, fd);
        else if ($fscanf(fd, "%h %d %d %d %d", b, stop, fe, ov, delay) == 5)
          run_case(tok, b[7:0], stop, fe, ov, delay);
        else bad_cases++;
      end
      $fclose(fd);
    end
    // let the last frames and handshakes finish
    n = 0;
    while (acks_done != acks_sent || !chk.drained()) tick_or_quit(n, "last transfers");
    finish_run();
  end

endmodule

`default_nettype wire
